// ==== common/cemf_pkg.sv ====
package cemf_pkg;

	// Counter and field widths
	typedef logic [15:0] cemf_cnt_t;	// CEMF cycles seen in a step
	typedef logic [15:0] tmo_cnt_t;		// Step timeout in clocks
	typedef logic [6:0]  step_t;		// Step number, first step is 1
	typedef logic [15:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;	// APB read data, also the system word
	typedef logic [7:0]  cycles_t;		// 8-bit CEMF cycle field

	// First timing word in the APB memory
	localparam apb_addr_t ADDR_START = 16'd8;

	// System word fields
	localparam int SYS_RUN_BIT   = 0;	// Run request
	localparam int SYS_CONF_BIT  = 1;	// TDC configuration request
	localparam int SYS_STEPS_LSB = 2;
	localparam int SYS_STEPS_MSB = 8;

	// Timing word field offsets
	localparam int TW_CYCLES = 0;	// Cycles between start and stop, 8 bits
	localparam int TW_DELAY  = 8;	// Cycles before start, 8 bits
	localparam int TW_TMO    = 16;	// Step timeout, 16 bits

	// Configuration and measurement sequence
	typedef enum logic [4:0] {
		st_idle, st_conf_a, st_wait_conf_a, st_conf_b, st_wait_conf_b,
		st_end_conf,
		st_init, st_fetch, st_meas_start, st_cnt_on,
		st_wait_start, st_start_gen, st_wait_stop, st_stop_gen,
		st_step_end, st_int_wait, st_tmo_wait,
		st_last_int_wait, st_last_tmo_wait, st_last_read, st_read_wait
	} seq_state_e;

endpackage

// ==== src/input_sync.sv ====
`timescale 1ns/1ns

module input_sync (
	input  logic clk,
	input  logic rst_n,
	input  logic cemf_i,		// CEMF comparator output, async
	input  logic trigger_i,
	input  logic intb_a_i,
	input  logic intb_b_i,
	output logic cemf_rise_o,
	output logic cemf_fall_o,
	output logic trigger_o,		// Synchronized level
	output logic intb_a_fall_o,
	output logic intb_b_fall_o
);

	// Bit order: intb_b, intb_a, trigger, cemf
	logic [3:0] raw;
	logic [3:0] s0, s1, s2;		// Three flop stages per input

	assign raw = {intb_b_i, intb_a_i, trigger_i, cemf_i};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			s0 <= '0;
			s1 <= '0;
			s2 <= '0;
		end
		else
		begin
			s0 <= raw;
			s1 <= s0;
			s2 <= s1;
		end
	end

	// Edges taken between the last two stages
	assign cemf_rise_o   = s1[0] & ~s2[0];
	assign cemf_fall_o   = ~s1[0] & s2[0];
	assign trigger_o     = s2[1];
	assign intb_a_fall_o = ~s1[2] & s2[2];	// INTB is active low
	assign intb_b_fall_o = ~s1[3] & s2[3];

endmodule

// ==== src/event_counters.sv ====
`timescale 1ns/1ns

module event_counters (
	input  logic clk,
	input  logic rst_n,
	input  logic en_cemf_i,
	input  logic cemf_rise_i,
	input  logic en_tmo_i,
	input  logic step_clr_i,	// Start of a run
	input  logic step_inc_i,
	output cemf_pkg::cemf_cnt_t cemf_cnt_o,
	output cemf_pkg::tmo_cnt_t  tmo_cnt_o,
	output cemf_pkg::step_t     step_o
);

	import cemf_pkg::*;

	// CEMF rising edges since the counters-on state
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			cemf_cnt_o <= '0;
		else if (!en_cemf_i || step_clr_i)
			cemf_cnt_o <= '0;	// Held at zero outside the pulse windows
		else if (cemf_rise_i)
			cemf_cnt_o <= cemf_cnt_o + cemf_cnt_t'(1);
	end

	// Clocks since the counters-on state
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tmo_cnt_o <= '0;
		else if (!en_tmo_i || step_clr_i)
			tmo_cnt_o <= '0;
		else
			tmo_cnt_o <= tmo_cnt_o + tmo_cnt_t'(1);
	end

	// Step number, loaded to 1 when a run begins
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			step_o <= '0;
		else if (step_clr_i)
			step_o <= step_t'(1);
		else if (step_inc_i)
			step_o <= step_o + step_t'(1);	// Advances once per step end
	end

endmodule

// ==== sequencer/apb_fetch.sv ====
`timescale 1ns/1ns

module apb_fetch (
	input  logic clk,
	input  logic rst_n,
	input  logic fetch_i,		// Start one read
	input  logic step_next_i,
	input  logic step_last_i,
	input  logic pready_i,
	input  cemf_pkg::apb_data_t prdata_i,
	output logic psel_o,
	output logic penable_o,
	output logic done_o,		// One clock, fields valid next clock
	output cemf_pkg::apb_addr_t paddr_o,
	output cemf_pkg::cycles_t   delay_o,
	output cemf_pkg::cycles_t   cycles_o,
	output cemf_pkg::tmo_cnt_t  tmo_o
);

	import cemf_pkg::*;

	// Two setup clocks, then access until pready
	typedef enum logic [1:0] {ph_idle, ph_setup, ph_hold, ph_access} phase_e;

	phase_e phase;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= ph_idle;
		else
		begin
			case (phase)
				ph_idle:   if (fetch_i) phase <= ph_setup;
				ph_setup:  phase <= ph_hold;
				ph_hold:   phase <= ph_access;
				ph_access: if (pready_i) phase <= ph_idle;	// Wait states here only
				default:   phase <= ph_idle;
			endcase
		end
	end

	assign psel_o    = (phase != ph_idle);
	assign penable_o = (phase == ph_access);
	assign done_o    = penable_o & pready_i;

	// Timing word address, one word per step
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			paddr_o <= ADDR_START;
		else if (step_last_i)
			paddr_o <= ADDR_START;	// Rewind for the next run
		else if (step_next_i)
			paddr_o <= paddr_o + apb_addr_t'(1);
	end

	// Field capture on the completing access
	always_ff @(posedge clk)
	begin
		if (done_o)
		begin
			cycles_o <= prdata_i[TW_CYCLES +: $bits(cycles_t)];
			delay_o  <= prdata_i[TW_DELAY +: $bits(cycles_t)];
			tmo_o    <= prdata_i[TW_TMO +: $bits(tmo_cnt_t)];
		end
	end

endmodule

// ==== sequencer/seq_fsm.sv ====
`timescale 1ns/1ns

module seq_fsm (
	input  logic clk,
	input  logic rst_n,
	input  cemf_pkg::apb_data_t system_word_i,
	input  logic end_conf_a_i,
	input  logic end_conf_b_i,
	input  logic end_read_a_i,
	input  logic end_read_b_i,
	input  logic cemf_rise_i,
	input  logic cemf_fall_i,
	input  logic trigger_i,
	input  logic intb_a_fall_i,
	input  logic intb_b_fall_i,
	input  logic fetch_done_i,
	input  cemf_pkg::cemf_cnt_t cemf_cnt_i,
	input  cemf_pkg::tmo_cnt_t  tmo_cnt_i,
	input  cemf_pkg::tmo_cnt_t  tmo_i,
	input  cemf_pkg::step_t     step_i,
	input  cemf_pkg::cycles_t   delay_i,
	input  cemf_pkg::cycles_t   cycles_i,
	output logic start_conf_a_o,
	output logic start_conf_b_o,
	output logic start_op_a_o,
	output logic start_op_b_o,
	output logic start_read_a_o,
	output logic start_read_b_o,
	output logic clr_sys_reg_o,
	output logic en_fe_o,
	output logic start_gen_o,
	output logic stop_gen_o,
	output logic ctrl_tdc_o,
	output logic frame_o,
	output logic next_sequence_o,
	output logic stop_fpga2_o,
	output logic fetch_o,
	output logic step_next_o,
	output logic step_last_o,
	output logic en_cemf_o,
	output logic en_tmo_o,
	output logic step_clr_o,
	output logic step_inc_o
);

	import cemf_pkg::*;

	seq_state_e state_q, state_d;
	logic bank_q, bank_d;		// 1: bank B measures next
	logic ctrl_q, ctrl_d;		// TDC mux select
	logic frame_q, frame_d;
	logic run, conf, is_last, int_fall;
	step_t steps;
	cemf_cnt_t stop_thr;

	assign run      = system_word_i[SYS_RUN_BIT];
	assign conf     = system_word_i[SYS_CONF_BIT];
	assign steps    = system_word_i[SYS_STEPS_MSB:SYS_STEPS_LSB];
	assign is_last  = (step_i == steps);
	assign int_fall = intb_a_fall_i | intb_b_fall_i;
	assign stop_thr = cemf_cnt_t'(delay_i) + cemf_cnt_t'(cycles_i);	// Stop edge count

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state_q <= st_idle;
			bank_q  <= 1'b0;
			ctrl_q  <= 1'b0;
			frame_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			bank_q  <= bank_d;
			ctrl_q  <= ctrl_d;
			frame_q <= frame_d;
		end
	end

	assign ctrl_tdc_o = ctrl_q;
	assign frame_o    = frame_q;

	always_comb
	begin
		state_d = state_q;
		bank_d  = bank_q;
		ctrl_d  = ctrl_q;
		frame_d = frame_q;
		{start_conf_a_o, start_conf_b_o, clr_sys_reg_o} = '0;
		{start_op_a_o, start_op_b_o, start_read_a_o, start_read_b_o} = '0;
		{en_fe_o, start_gen_o, stop_gen_o, next_sequence_o, stop_fpga2_o} = '0;
		{fetch_o, step_next_o, step_last_o, step_clr_o, step_inc_o} = '0;
		en_cemf_o = 1'b0;
		en_tmo_o  = 1'b0;
		// Pulse window and step phases share the front end enable
		if (state_q inside {[st_meas_start:st_last_tmo_wait]})
			en_fe_o = 1'b1;
		if (state_q inside {[st_fetch:st_int_wait], st_last_int_wait})
			next_sequence_o = 1'b1;
		if (state_q inside {[st_cnt_on:st_last_tmo_wait]})
			en_tmo_o = 1'b1;	// Timeout runs until the step closes
		if (state_q inside {[st_cnt_on:st_stop_gen]})
			en_cemf_o = 1'b1;
		case (state_q)
			st_idle:
			begin
				stop_fpga2_o = ~run;
				bank_d = 1'b0;
				frame_d = 1'b0;
				if (run)
				begin
					step_clr_o = 1'b1;	// Step counter to 1
					state_d = st_init;
				end
				else if (conf)
					state_d = st_conf_a;
			end
			st_conf_a:
			begin
				stop_fpga2_o = 1'b1;
				start_conf_a_o = 1'b1;
				state_d = st_wait_conf_a;
			end
			st_wait_conf_a:
			begin
				stop_fpga2_o = 1'b1;
				if (end_conf_a_i)
					state_d = st_conf_b;
			end
			st_conf_b:
			begin
				stop_fpga2_o = 1'b1;
				start_conf_b_o = 1'b1;
				state_d = st_wait_conf_b;
			end
			st_wait_conf_b:
			begin
				stop_fpga2_o = 1'b1;
				if (end_conf_b_i)
					state_d = st_end_conf;
			end
			st_end_conf:
			begin
				stop_fpga2_o = 1'b1;
				clr_sys_reg_o = 1'b1;	// Drop the config bit in the system register
				state_d = st_idle;
			end
			st_init:
			begin
				stop_fpga2_o = ~run;
				fetch_o = run;
				state_d = run ? st_fetch : st_idle;	// Run cleared aborts between steps
			end
			st_fetch:
				if (fetch_done_i) state_d = st_meas_start;
			st_meas_start:
			begin
				bank_d = ~bank_q;
				if (step_i == step_t'(1))
				begin
					frame_d = 1'b1;
					start_op_a_o = 1'b1;	// Nothing to read yet
				end
				else if (!bank_q)
				begin
					start_op_a_o = 1'b1;
					start_read_b_o = 1'b1;
				end
				else
				begin
					start_op_b_o = 1'b1;
					start_read_a_o = 1'b1;
				end
				state_d = st_cnt_on;
			end
			st_cnt_on:
				state_d = st_wait_start;
			st_wait_start:
				if (cemf_rise_i && cemf_cnt_i >= cemf_cnt_t'(delay_i) && trigger_i)
					state_d = st_start_gen;
			st_start_gen:
			begin
				start_gen_o = 1'b1;
				if (cemf_fall_i) state_d = st_wait_stop;
			end
			st_wait_stop:
				if (cemf_rise_i && cemf_cnt_i >= stop_thr) state_d = st_stop_gen;
			st_stop_gen:
			begin
				stop_gen_o = 1'b1;
				if (cemf_fall_i) state_d = st_step_end;
			end
			st_step_end:
			begin
				step_inc_o = 1'b1;
				step_last_o = is_last;
				step_next_o = ~is_last;
				state_d = is_last ? st_last_int_wait : st_int_wait;
			end
			st_int_wait, st_last_int_wait:
			begin
				// A-side interrupt steers the mux to B
				if (intb_a_fall_i)
					ctrl_d = 1'b1;
				else if (intb_b_fall_i)
					ctrl_d = 1'b0;
				if (int_fall)
					state_d = (state_q == st_int_wait) ? st_tmo_wait : st_last_tmo_wait;
			end
			st_tmo_wait:
				if (tmo_cnt_i >= tmo_i) state_d = st_init;
			st_last_tmo_wait:
				if (tmo_cnt_i >= tmo_i) state_d = st_last_read;
			st_last_read:
			begin
				// Bank still holding the last step's data
				if (!bank_q)
					start_read_b_o = 1'b1;
				else
					start_read_a_o = 1'b1;
				bank_d = 1'b0;
				state_d = st_read_wait;
			end
			st_read_wait:
				if (end_read_a_i || end_read_b_i)
				begin
					frame_d = 1'b0;	// Frame closes with the final readout
					state_d = st_idle;
				end
			default:
				state_d = st_idle;
		endcase
	end

endmodule

// ==== src/cemf_sequencer_top.sv ====
`timescale 1ns/1ns

module cemf_sequencer_top (
	input  logic clk,
	input  logic rst_n,
	input  cemf_pkg::apb_data_t system_word_i,
	input  logic end_conf_a_i,
	input  logic end_conf_b_i,
	input  logic end_read_a_i,
	input  logic end_read_b_i,
	input  logic cemf_i,
	input  logic trigger_i,
	input  logic intb_a_i,
	input  logic intb_b_i,
	input  cemf_pkg::apb_data_t prdata_i,
	input  logic pready_i,
	output logic start_conf_a_o,
	output logic start_conf_b_o,
	output logic start_op_a_o,
	output logic start_op_b_o,
	output logic start_read_a_o,
	output logic start_read_b_o,
	output logic clr_sys_reg_o,
	output logic en_fe_o,
	output logic start_gen_o,
	output logic stop_gen_o,
	output logic ctrl_tdc_o,
	output logic frame_o,
	output logic next_sequence_o,
	output logic stop_fpga2_o,
	output logic psel_o,
	output logic penable_o,
	output cemf_pkg::apb_addr_t paddr_o
);

	import cemf_pkg::*;

	// Synchronized events
	logic cemf_rise, cemf_fall, trigger_s, intb_a_fall, intb_b_fall;
	// Counter controls and values
	logic en_cemf, en_tmo, step_clr, step_inc;
	cemf_cnt_t cemf_cnt;
	tmo_cnt_t tmo_cnt;
	step_t step;
	// Fetch unit handshake and timing fields
	logic fetch, fetch_done, step_next, step_last;
	cycles_t delay, cycles;
	tmo_cnt_t tmo;

	input_sync u_sync (
		.clk(clk), .rst_n(rst_n),
		.cemf_i(cemf_i), .trigger_i(trigger_i), .intb_a_i(intb_a_i), .intb_b_i(intb_b_i),
		.cemf_rise_o(cemf_rise), .cemf_fall_o(cemf_fall), .trigger_o(trigger_s),
		.intb_a_fall_o(intb_a_fall), .intb_b_fall_o(intb_b_fall)
	);

	event_counters u_cnt (
		.clk(clk), .rst_n(rst_n),
		.en_cemf_i(en_cemf), .cemf_rise_i(cemf_rise), .en_tmo_i(en_tmo),
		.step_clr_i(step_clr), .step_inc_i(step_inc),
		.cemf_cnt_o(cemf_cnt), .tmo_cnt_o(tmo_cnt), .step_o(step)
	);

	apb_fetch u_fetch (
		.clk(clk), .rst_n(rst_n),
		.fetch_i(fetch), .step_next_i(step_next), .step_last_i(step_last),
		.pready_i(pready_i), .prdata_i(prdata_i),
		.psel_o(psel_o), .penable_o(penable_o), .done_o(fetch_done), .paddr_o(paddr_o),
		.delay_o(delay), .cycles_o(cycles), .tmo_o(tmo)
	);

	seq_fsm u_fsm (
		.clk(clk), .rst_n(rst_n), .system_word_i(system_word_i),
		.end_conf_a_i(end_conf_a_i), .end_conf_b_i(end_conf_b_i),
		.end_read_a_i(end_read_a_i), .end_read_b_i(end_read_b_i),
		.cemf_rise_i(cemf_rise), .cemf_fall_i(cemf_fall), .trigger_i(trigger_s),
		.intb_a_fall_i(intb_a_fall), .intb_b_fall_i(intb_b_fall), .fetch_done_i(fetch_done),
		.cemf_cnt_i(cemf_cnt), .tmo_cnt_i(tmo_cnt), .tmo_i(tmo), .step_i(step),
		.delay_i(delay), .cycles_i(cycles),
		.start_conf_a_o(start_conf_a_o), .start_conf_b_o(start_conf_b_o),
		.start_op_a_o(start_op_a_o), .start_op_b_o(start_op_b_o),
		.start_read_a_o(start_read_a_o), .start_read_b_o(start_read_b_o),
		.clr_sys_reg_o(clr_sys_reg_o), .en_fe_o(en_fe_o),
		.start_gen_o(start_gen_o), .stop_gen_o(stop_gen_o), .ctrl_tdc_o(ctrl_tdc_o),
		.frame_o(frame_o), .next_sequence_o(next_sequence_o), .stop_fpga2_o(stop_fpga2_o),
		.fetch_o(fetch), .step_next_o(step_next), .step_last_o(step_last),
		.en_cemf_o(en_cemf), .en_tmo_o(en_tmo), .step_clr_o(step_clr), .step_inc_o(step_inc)
	);

endmodule

// ==== test/cemf_sva.sv ====
`timescale 1ns/1ns

module cemf_sva (
	input logic clk,
	input logic rst_n,
	input logic start_conf_a_o,
	input logic start_conf_b_o,
	input logic start_op_a_o,
	input logic start_op_b_o,
	input logic start_read_a_o,
	input logic start_read_b_o,
	input logic clr_sys_reg_o,
	input logic start_gen_o,
	input logic stop_gen_o,
	input logic psel_o,
	input logic penable_o
);

	// Strobes are single-clock pulses
	a_conf_a: assert property (@(posedge clk) disable iff (!rst_n)
		start_conf_a_o |=> !start_conf_a_o) else $error("start_conf_a_o held past one clock");
	a_conf_b: assert property (@(posedge clk) disable iff (!rst_n)
		start_conf_b_o |=> !start_conf_b_o) else $error("start_conf_b_o held past one clock");
	a_op_a: assert property (@(posedge clk) disable iff (!rst_n)
		start_op_a_o |=> !start_op_a_o) else $error("start_op_a_o held past one clock");
	a_op_b: assert property (@(posedge clk) disable iff (!rst_n)
		start_op_b_o |=> !start_op_b_o) else $error("start_op_b_o held past one clock");
	a_rd_a: assert property (@(posedge clk) disable iff (!rst_n)
		start_read_a_o |=> !start_read_a_o) else $error("start_read_a_o held past one clock");
	a_rd_b: assert property (@(posedge clk) disable iff (!rst_n)
		start_read_b_o |=> !start_read_b_o) else $error("start_read_b_o held past one clock");
	a_clr: assert property (@(posedge clk) disable iff (!rst_n)
		clr_sys_reg_o |=> !clr_sys_reg_o) else $error("clr_sys_reg_o held past one clock");

	// APB access phase only inside a selected transfer
	a_pen: assert property (@(posedge clk) disable iff (!rst_n)
		penable_o |-> psel_o) else $error("penable_o high without psel_o");

	a_windows: assert property (@(posedge clk) disable iff (!rst_n)
		!(start_gen_o && stop_gen_o)) else $error("start and stop windows overlap");

endmodule

// FSM strobes and APB outputs of the sequencer top level
bind cemf_sequencer_top cemf_sva sva_i (
	.clk(clk), .rst_n(rst_n),
	.start_conf_a_o(start_conf_a_o), .start_conf_b_o(start_conf_b_o),
	.start_op_a_o(start_op_a_o), .start_op_b_o(start_op_b_o),
	.start_read_a_o(start_read_a_o), .start_read_b_o(start_read_b_o),
	.clr_sys_reg_o(clr_sys_reg_o), .start_gen_o(start_gen_o), .stop_gen_o(stop_gen_o),
	.psel_o(psel_o), .penable_o(penable_o)
);

// ==== test/cemf_checker.sv ====
`timescale 1ns/1ns

module cemf_checker (
	input logic clk,
	input logic rst_n,
	input cemf_pkg::apb_data_t system_word_i,
	input cemf_pkg::apb_data_t prdata_i,
	input logic cemf_i,
	input logic trigger_i,
	input logic end_conf_a_i,
	input logic end_conf_b_i,
	input logic end_read_a_i,
	input logic end_read_b_i,
	input logic intb_a_i,
	input logic intb_b_i,
	input logic pready_i,
	input logic start_conf_a_o,
	input logic start_conf_b_o,
	input logic start_op_a_o,
	input logic start_op_b_o,
	input logic start_read_a_o,
	input logic start_read_b_o,
	input logic clr_sys_reg_o,
	input logic en_fe_o,
	input logic start_gen_o,
	input logic stop_gen_o,
	input logic ctrl_tdc_o,
	input logic frame_o,
	input logic next_sequence_o,
	input logic stop_fpga2_o,
	input logic psel_o,
	input logic penable_o,
	input cemf_pkg::apb_addr_t paddr_o,
	output int errors_o
);

	import cemf_pkg::*;

	int errors = 0;
	int step = 0;		// Timing words fetched in this run
	int ops = 0;		// Op strobes seen in this run
	int conf_ph = 0;	// Position in the configuration sequence
	int nsteps;
	logic [2:0] cemf_d, trig_d, ia_d, ib_d;	// Three-clock input delay
	logic fe_q, sg_q, sp_q, psel_q, pen_q, rdy_q, frame_q, rise_q, trig_q;
	logic ctrl_m;		// Expected TDC mux select
	logic rd_end_q, last_rd;
	cemf_cnt_t cnt, cnt_q;
	cycles_t delay, cycles;
	apb_addr_t exp_addr;

	assign errors_o = errors;
	assign nsteps = int'(system_word_i[SYS_STEPS_MSB:SYS_STEPS_LSB]);

	task automatic report_mismatch(string name, int got, int exp);
		errors++;
		$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
	endtask

	task automatic report_error(string what);
		errors++;
		$display("error at %0t: %s", $time, what);
	endtask

	always @(posedge clk)
	begin
		logic rise;
		logic [3:0] got, exp;
		logic [14:0] quiet;
		rise = cemf_d[1] & ~cemf_d[2];
		quiet = {start_conf_a_o, start_conf_b_o, start_op_a_o, start_op_b_o, start_read_a_o,
			start_read_b_o, clr_sys_reg_o, en_fe_o, start_gen_o, stop_gen_o, frame_o,
			psel_o, penable_o, ctrl_tdc_o, next_sequence_o};
		cemf_d <= {cemf_d[1:0], cemf_i};
		trig_d <= {trig_d[1:0], trigger_i};
		ia_d <= {ia_d[1:0], intb_a_i};
		ib_d <= {ib_d[1:0], intb_b_i};
		rd_end_q <= end_read_a_i | end_read_b_i;
		fe_q <= en_fe_o;
		sg_q <= start_gen_o;
		sp_q <= stop_gen_o;
		psel_q <= psel_o;
		pen_q <= penable_o;
		rdy_q <= pready_i;
		frame_q <= frame_o;
		rise_q <= rise;
		cnt_q <= cnt;
		trig_q <= trig_d[2];
		if (!rst_n)
		begin
			// Everything quiet in reset, stop_fpga2 follows the run bit
			if (quiet != '0)
				report_mismatch("outputs in reset", int'(quiet), 0);
			if (stop_fpga2_o != !system_word_i[SYS_RUN_BIT])
				report_mismatch("stop_fpga2_o", int'(stop_fpga2_o),
					int'(!system_word_i[SYS_RUN_BIT]));
			cemf_d <= '0;
			trig_d <= '0;
			ia_d <= '0;
			ib_d <= '0;
			ctrl_m <= 1'b0;
			cnt <= '0;
			step = 0;
			ops = 0;
			last_rd = 1'b0;
			conf_ph = 0;
		end
		else
		begin
			// CEMF edges counted from the counters-on state
			if (!en_fe_o)
				cnt <= '0;
			else if (fe_q && rise)
				cnt <= cnt + cemf_cnt_t'(1);

			if (penable_o && pready_i)
			begin
				cycles <= prdata_i[TW_CYCLES +: 8];
				delay <= prdata_i[TW_DELAY +: 8];
			end

			if (start_gen_o && !sg_q)
				if (!rise_q || !trig_q || cnt_q < cemf_cnt_t'(delay))
					report_error("start_gen_o rose without a qualifying CEMF edge");
			if (stop_gen_o && !sp_q)
				if (!rise_q || cnt_q < cemf_cnt_t'(delay) + cemf_cnt_t'(cycles))
					report_error("stop_gen_o rose before delay plus cycles edges");

			// One read per step, address follows the step
			if (psel_o && !psel_q)
			begin
				step++;
				exp_addr = apb_addr_t'(int'(ADDR_START) + step - 1);
				if (paddr_o != exp_addr)
					report_mismatch("paddr_o", int'(paddr_o), int'(exp_addr));
			end
			if (penable_o && !pen_q && !psel_q)
				report_error("penable_o without a setup phase");
			if (pen_q && !rdy_q && !penable_o)
				report_error("penable_o dropped before pready");

			// Ping-pong banks, final read from the bank still full
			if (start_op_a_o | start_op_b_o | start_read_a_o | start_read_b_o)
			begin
				got = {start_op_a_o, start_op_b_o, start_read_a_o, start_read_b_o};
				if (!en_fe_o)
				begin
					last_rd = 1'b1;
					exp = (nsteps % 2 == 1) ? 4'b0010 : 4'b0001;
				end
				else if (step == 1)
					exp = 4'b1000;
				else
					exp = (step % 2 == 0) ? 4'b0110 : 4'b1001;
				if (got != exp)
					report_mismatch("tdc strobes", int'(got), int'(exp));
				if (start_op_a_o || start_op_b_o)
					ops++;
			end

			// Mux select set by an A interrupt, cleared by a B interrupt
			if (ctrl_tdc_o != ctrl_m)
				report_mismatch("ctrl_tdc_o", int'(ctrl_tdc_o), int'(ctrl_m));
			if (!ia_d[1] && ia_d[2])
				ctrl_m <= 1'b1;
			else if (!ib_d[1] && ib_d[2])
				ctrl_m <= 1'b0;

			if (frame_o && !frame_q && step != 1)
				report_mismatch("frame_o rise step", step, 1);
			if (!frame_o && frame_q)
			begin
				// Frame closes only on the end of the final readout
				if (!last_rd || !rd_end_q)
					report_error("frame_o fell without the end of the final readout");
				if (ops != nsteps)
					report_mismatch("start_op strobes", ops, nsteps);
				step = 0;	// Run over
				ops = 0;
				last_rd = 1'b0;
				if (stop_fpga2_o != !system_word_i[SYS_RUN_BIT])
					report_mismatch("stop_fpga2_o", int'(stop_fpga2_o),
						int'(!system_word_i[SYS_RUN_BIT]));
			end

			// Expected order: conf A, end A, conf B, end B, clear
			if (start_conf_a_o)
			begin
				if (conf_ph != 0)
					report_error("start_conf_a_o out of order");
				conf_ph = 1;
			end
			if (end_conf_a_i && conf_ph == 1)
				conf_ph = 2;
			if (start_conf_b_o)
			begin
				if (conf_ph != 2)
					report_error("start_conf_b_o before end_conf_a");
				conf_ph = 3;
			end
			if (end_conf_b_i && conf_ph == 3)
				conf_ph = 4;
			if (clr_sys_reg_o)
			begin
				if (conf_ph != 4)
					report_error("clr_sys_reg_o before end_conf_b");
				conf_ph = 0;
			end
		end
	end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;

	import cemf_pkg::*;

	logic clk, rst_n;
	apb_data_t system_word, prdata;
	logic end_conf_a, end_conf_b, end_read_a, end_read_b;
	logic cemf, trigger, intb_a, intb_b, pready;
	logic start_conf_a, start_conf_b, start_op_a, start_op_b, start_read_a, start_read_b;
	logic clr_sys_reg, en_fe, start_gen, stop_gen, ctrl_tdc, frame, next_sequence, stop_fpga2;
	logic psel, penable;
	apb_addr_t paddr;
	apb_data_t mem [0:15];	// Timing words, indexed by paddr
	int cemf_half, conf_a_dly, conf_b_dly, rd_a_dly, rd_b_dly, int_dly, int_low;
	logic last_op_b, stop_q, hung;
	int check_errors, timeouts, nsteps;

	cemf_sequencer_top dut_i (
		.clk(clk), .rst_n(rst_n), .system_word_i(system_word),
		.end_conf_a_i(end_conf_a), .end_conf_b_i(end_conf_b),
		.end_read_a_i(end_read_a), .end_read_b_i(end_read_b),
		.cemf_i(cemf), .trigger_i(trigger), .intb_a_i(intb_a), .intb_b_i(intb_b),
		.prdata_i(prdata), .pready_i(pready),
		.start_conf_a_o(start_conf_a), .start_conf_b_o(start_conf_b),
		.start_op_a_o(start_op_a), .start_op_b_o(start_op_b),
		.start_read_a_o(start_read_a), .start_read_b_o(start_read_b),
		.clr_sys_reg_o(clr_sys_reg), .en_fe_o(en_fe), .start_gen_o(start_gen),
		.stop_gen_o(stop_gen), .ctrl_tdc_o(ctrl_tdc), .frame_o(frame),
		.next_sequence_o(next_sequence), .stop_fpga2_o(stop_fpga2),
		.psel_o(psel), .penable_o(penable), .paddr_o(paddr)
	);

	cemf_checker u_check (
		.clk(clk), .rst_n(rst_n), .system_word_i(system_word), .prdata_i(prdata),
		.cemf_i(cemf), .trigger_i(trigger), .end_conf_a_i(end_conf_a),
		.end_conf_b_i(end_conf_b), .end_read_a_i(end_read_a), .end_read_b_i(end_read_b),
		.intb_a_i(intb_a), .intb_b_i(intb_b), .pready_i(pready),
		.start_conf_a_o(start_conf_a), .start_conf_b_o(start_conf_b),
		.start_op_a_o(start_op_a), .start_op_b_o(start_op_b),
		.start_read_a_o(start_read_a), .start_read_b_o(start_read_b),
		.clr_sys_reg_o(clr_sys_reg), .en_fe_o(en_fe), .start_gen_o(start_gen),
		.stop_gen_o(stop_gen), .ctrl_tdc_o(ctrl_tdc), .frame_o(frame),
		.next_sequence_o(next_sequence), .stop_fpga2_o(stop_fpga2),
		.psel_o(psel), .penable_o(penable), .paddr_o(paddr), .errors_o(check_errors)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic apb_data_t random_timing_word();
		tmo_cnt_t t;
		cycles_t d, c;
		t = tmo_cnt_t'(10 + $urandom % 40);	// Short step timeouts
		d = cycles_t'($urandom % 4);
		c = cycles_t'($urandom % 4);
		return {t, d, c};
	endfunction

	task automatic note_timeout(string what);
		hung = 1'b1;
		timeouts++;
		$display("timeout at %0t waiting for %s", $time, what);
	endtask

	// Responders: CEMF source, APB slave, TDC and config/readout ends
	always @(posedge clk)
	begin
		if (cemf_half <= 1)
		begin
			cemf <= ~cemf;
			cemf_half <= 3 + int'($urandom % 6);
			if (!cemf)
				trigger <= (($urandom % 4) != 0);	// Mostly armed
		end
		else
			cemf_half <= cemf_half - 1;
		pready <= (($urandom % 3) == 0);
		prdata <= mem[paddr[3:0]];
		if (start_conf_a) conf_a_dly <= 2 + int'($urandom % 5);
		else if (conf_a_dly > 0) conf_a_dly <= conf_a_dly - 1;
		if (start_conf_b) conf_b_dly <= 2 + int'($urandom % 5);
		else if (conf_b_dly > 0) conf_b_dly <= conf_b_dly - 1;
		if (start_read_a) rd_a_dly <= 2 + int'($urandom % 6);
		else if (rd_a_dly > 0) rd_a_dly <= rd_a_dly - 1;
		if (start_read_b) rd_b_dly <= 2 + int'($urandom % 6);
		else if (rd_b_dly > 0) rd_b_dly <= rd_b_dly - 1;
		end_conf_a <= (conf_a_dly == 1);
		end_conf_b <= (conf_b_dly == 1);
		end_read_a <= (rd_a_dly == 1);
		end_read_b <= (rd_b_dly == 1);
		// Interrupt from the measuring bank after the stop window
		stop_q <= stop_gen;
		if (start_op_a || start_op_b) last_op_b <= start_op_b;
		if (stop_q && !stop_gen) int_dly <= 2 + int'($urandom % 8);
		else if (int_dly > 0) int_dly <= int_dly - 1;
		if (int_dly == 1)
		begin
			int_low <= 4;
			if (last_op_b) intb_b <= 1'b0;
			else intb_a <= 1'b0;
		end
		else if (int_low > 0)
		begin
			int_low <= int_low - 1;
			if (int_low == 1)
			begin
				intb_a <= 1'b1;
				intb_b <= 1'b1;
			end
		end
	end

	task automatic configure_tdcs();
		int i;
		if (hung) return;
		system_word <= apb_data_t'(1) << SYS_CONF_BIT;
		for (i = 0; i < 500 && !clr_sys_reg; i++)
			@(posedge clk);
		if (!clr_sys_reg) note_timeout("clr_sys_reg_o after configuration");
		system_word <= '0;
		@(posedge clk);
	endtask

	task automatic run_sequence();
		int i, done_cnt;
		apb_data_t steps_field;
		if (hung) return;
		nsteps = 1 + int'($urandom % 5);
		for (i = 0; i < 16; i++)
			mem[i] = random_timing_word();
		steps_field = apb_data_t'(nsteps) << SYS_STEPS_LSB;
		system_word <= steps_field | (apb_data_t'(1) << SYS_RUN_BIT);
		done_cnt = 0;
		for (i = 0; i < 20000 && done_cnt < nsteps; i++)
		begin
			@(posedge clk);
			if (penable && pready) done_cnt++;
		end
		if (done_cnt < nsteps)
		begin
			note_timeout("the last timing word read");
			return;
		end
		system_word <= steps_field;	// Run bit off, step count kept
		for (i = 0; i < 200 && !frame; i++)
			@(posedge clk);
		if (!frame)
		begin
			note_timeout("frame_o to rise");
			return;
		end
		for (i = 0; i < 20000 && frame; i++)
			@(posedge clk);
		if (frame) note_timeout("frame_o to fall after the last read");
		repeat (4) @(posedge clk);
	endtask

	initial
	begin
		void'($urandom(32'h82975fdb));
		rst_n = 1'b0;
		system_word = '0;
		prdata = '0;
		{end_conf_a, end_conf_b, end_read_a, end_read_b} = '0;
		{cemf, trigger, pready} = '0;
		intb_a = 1'b1;
		intb_b = 1'b1;
		{cemf_half, conf_a_dly, conf_b_dly, rd_a_dly, rd_b_dly, int_dly, int_low} = '0;
		last_op_b = 1'b0;
		stop_q = 1'b0;
		hung = 1'b0;
		timeouts = 0;
		for (int a = 0; a < 16; a++)
			mem[a] = random_timing_word();
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		configure_tdcs();
		for (int r = 0; r < 6; r++)
		begin
			if (r == 3) configure_tdcs();
			run_sequence();
		end
		repeat (5) @(posedge clk);
		$display("checker errors %0d, timeouts %0d", check_errors, timeouts);
		if (check_errors == 0 && timeouts == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== compile.f ====
common/cemf_pkg.sv
src/input_sync.sv
src/event_counters.sv
sequencer/apb_fetch.sv
sequencer/seq_fsm.sv
src/cemf_sequencer_top.sv
test/cemf_sva.sv
test/cemf_checker.sv
test/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_top -f compile.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Finished with no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
